/* alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic [isaPkg::wordWidth-1:0] opA,
    input  logic [isaPkg::wordWidth-1:0] opB,
    input  cpuPkg::aluOpT                aluOp,
    output logic [isaPkg::wordWidth-1:0] result
);
    import isaPkg::*;
    import cpuPkg::*;

    // carries and overflow are dropped.
    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = opA + opB;
            end
            aluSub: begin
                result = opA - opB;
            end
            aluAnd: begin
                result = opA & opB;
            end
            aluOr: begin
                result = opA | opB;
            end
            aluNot: begin
                result = ~opA;
            end
            aluTcp: begin
                result = ~opA + 1'b1;      // two's complement.
            end
            aluShl: begin
                result = opA << 1;
            end
            aluShr: begin
                result = {opA[wordWidth-1], opA[wordWidth-1:1]}; // sign kept.
            end
            aluLhi: begin
                result = opB << immWidth;
            end
            aluPassB: begin
                result = opB;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  logic [isaPkg::wordWidth-1:0] instr,
    output cpuPkg::ctrlWordT             ctrl
);
    import isaPkg::*;
    import cpuPkg::*;

    opcodeT opcode;
    funcT   func;

    assign opcode = opcodeT'(instr[wordWidth-1 -: opcodeWidth]);
    assign func   = funcT'(instr[funcWidth-1:0]);

    always_comb begin
        ctrl       = '0;           // unknown codes fall through as a no-op.
        ctrl.aluOp = aluPassB;
        case (opcode)
            opBne, opBeq, opBgz, opBlz: begin
                ctrl.branch = 1'b1;
            end
            opAdi, opOri, opLhi, opLwd, opSwd: begin
                ctrl.aluSrcImm  = 1'b1;
                ctrl.regWrite   = (opcode != opSwd);
                ctrl.memRead    = (opcode == opLwd);
                ctrl.memWrite   = (opcode == opSwd);
                ctrl.memToReg   = (opcode == opLwd);
                ctrl.zeroExtImm = (opcode == opOri);
                case (opcode)
                    opOri:   ctrl.aluOp = aluOr;
                    opLhi:   ctrl.aluOp = aluLhi;
                    default: ctrl.aluOp = aluAdd; // adi and the address sum.
                endcase
            end
            opJmp, opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = (opcode == opJal);
                ctrl.regWrite = (opcode == opJal);
            end
            opRtype: begin
                case (func)
                    fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp, fnShl, fnShr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        case (func)
                            fnAdd:   ctrl.aluOp = aluAdd;
                            fnSub:   ctrl.aluOp = aluSub;
                            fnAnd:   ctrl.aluOp = aluAnd;
                            fnOrr:   ctrl.aluOp = aluOr;
                            fnNot:   ctrl.aluOp = aluNot;
                            fnTcp:   ctrl.aluOp = aluTcp;
                            fnShl:   ctrl.aluOp = aluShl;
                            default: ctrl.aluOp = aluShr;
                        endcase
                    end
                    fnJpr: begin
                        ctrl.jumpReg = 1'b1;
                    end
                    fnJrl: begin
                        ctrl.jumpReg  = 1'b1;
                        ctrl.link     = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end
                    fnHlt: begin
                        ctrl.halt = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // each decoded word asks for at most one memory strobe.
    memExclusive: assert property (@(instr) !(ctrl.memRead && ctrl.memWrite));

endmodule

`default_nettype wire

/* cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu (
    input  logic                         clk,
    input  logic                         rstN,
    output logic                         readM,
    output logic                         writeM,
    output logic [isaPkg::wordWidth-1:0] address,
    output logic [isaPkg::wordWidth-1:0] writeData,
    input  logic [isaPkg::wordWidth-1:0] readData,
    input  logic                         inputReady,
    input  logic                         ackOutput,
    output logic                         halted
);
    import isaPkg::*;
    import cpuPkg::*;

    logic [wordWidth-1:0] instr;
    ctrlWordT             ctrl;   // decoded from instr in the same cycle.

    controlUnit i_controlUnit (
        .instr (instr),
        .ctrl  (ctrl)
    );

    datapath i_datapath (
        .clk        (clk),
        .rstN       (rstN),
        .ctrl       (ctrl),
        .instr      (instr),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .writeData  (writeData),
        .readData   (readData),
        .inputReady (inputReady),
        .ackOutput  (ackOutput),
        .halted     (halted)
    );

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int aluOpWidth = 4;

    typedef enum logic [aluOpWidth-1:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluTcp,
        aluShl,
        aluShr,
        aluLhi,   // operand b into the upper byte.
        aluPassB
    } aluOpT;

    typedef struct packed {
        logic  branch;
        logic  jump;       // jmp, jal.
        logic  jumpReg;    // jpr, jrl.
        logic  link;
        logic  memRead;
        logic  memWrite;
        logic  regWrite;
        logic  regDst;     // rd when set, else rt.
        logic  memToReg;
        logic  aluSrcImm;
        logic  zeroExtImm;
        aluOpT aluOp;
        logic  halt;
    } ctrlWordT;

    typedef enum logic [2:0] {
        seqFetch,
        seqExecute,
        seqMemAccess,
        seqWriteBack,
        seqHalted
    } seqStateT;

endpackage

`default_nettype wire

/* datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath (
    input  logic                         clk,
    input  logic                         rstN,
    input  cpuPkg::ctrlWordT             ctrl,
    output logic [isaPkg::wordWidth-1:0] instr,
    output logic                         readM,
    output logic                         writeM,
    output logic [isaPkg::wordWidth-1:0] address,
    output logic [isaPkg::wordWidth-1:0] writeData,
    input  logic [isaPkg::wordWidth-1:0] readData,
    input  logic                         inputReady,
    input  logic                         ackOutput,
    output logic                         halted
);
    import isaPkg::*;
    import cpuPkg::*;

    seqStateT                state;
    opcodeT                  opcode;
    logic [wordWidth-1:0]    pc;
    logic [wordWidth-1:0]    pcPlus1;
    logic [wordWidth-1:0]    pcNext;       // resolved in execute.
    logic [wordWidth-1:0]    aluOut;
    logic [wordWidth-1:0]    aluResult;
    logic [wordWidth-1:0]    memData;
    logic [wordWidth-1:0]    rsValue;
    logic [wordWidth-1:0]    rtValue;
    logic [wordWidth-1:0]    immExt;
    logic [wordWidth-1:0]    opB;
    logic [wordWidth-1:0]    regWriteValue;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] writeAddr;
    logic [immWidth-1:0]     imm;
    logic                    takeBranch;
    logic                    regWriteEn;
    logic                    reqIdle;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operands and write-back select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign opcode  = opcodeT'(instr[wordWidth-1 -: opcodeWidth]);
    assign rs      = instr[11:10];
    assign rt      = instr[9:8];
    assign rd      = instr[7:6];
    assign imm     = instr[immWidth-1:0];
    assign immExt  = ctrl.zeroExtImm ? {{(wordWidth-immWidth){1'b0}}, imm}
                                     : {{(wordWidth-immWidth){imm[immWidth-1]}}, imm};
    assign opB     = ctrl.aluSrcImm ? immExt : rtValue;
    assign pcPlus1 = pc + 1'b1;

    assign writeAddr     = ctrl.link ? linkReg : (ctrl.regDst ? rd : rt);
    assign regWriteValue = ctrl.link ? pcPlus1 : (ctrl.memToReg ? memData : aluResult);
    assign regWriteEn    = ctrl.regWrite && (state == seqWriteBack);

    assign address   = (state == seqMemAccess) ? aluResult : pc;
    assign writeData = rtValue;
    assign reqIdle   = !inputReady && !ackOutput; // previous reply fully gone.

    always_comb begin
        case (opcode)
            opBne:   takeBranch = (rsValue != rtValue);
            opBeq:   takeBranch = (rsValue == rtValue);
            opBgz:   takeBranch = ($signed(rsValue) > 0);
            opBlz:   takeBranch = ($signed(rsValue) < 0);
            default: takeBranch = 1'b0;
        endcase
        takeBranch = takeBranch && ctrl.branch;
    end

    regFile i_regFile (
        .clk         (clk),
        .rstN        (rstN),
        .readAddr1   (rs),
        .readAddr2   (rt),
        .writeAddr   (writeAddr),
        .writeEnable (regWriteEn),
        .writeValue  (regWriteValue),
        .readValue1  (rsValue),
        .readValue2  (rtValue)
    );

    alu i_alu (
        .opA    (rsValue),
        .opB    (opB),
        .aluOp  (ctrl.aluOp),
        .result (aluOut)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state  <= seqFetch;
            pc     <= '0;
            instr  <= '0;
            readM  <= 1'b0;
            writeM <= 1'b0;
            halted <= 1'b0;
        end else begin
            case (state)
                seqFetch: begin
                    if (readM && inputReady) begin
                        instr <= readData;
                        readM <= 1'b0;
                        state <= seqExecute;
                    end else if (!readM && reqIdle) begin
                        readM <= 1'b1;
                    end
                end
                seqExecute: begin
                    if (ctrl.halt) begin
                        halted <= 1'b1;
                        state  <= seqHalted;
                    end else if (ctrl.memRead || ctrl.memWrite) begin
                        state <= seqMemAccess;
                    end else begin
                        state <= seqWriteBack;
                    end
                end
                seqMemAccess: begin
                    if (readM && inputReady) begin
                        readM <= 1'b0;
                        state <= seqWriteBack;
                    end else if (writeM && ackOutput) begin
                        writeM <= 1'b0;
                        state  <= seqWriteBack;
                    end else if (!readM && !writeM && reqIdle) begin
                        readM  <= ctrl.memRead;
                        writeM <= ctrl.memWrite;
                    end
                end
                seqWriteBack: begin
                    pc    <= pcNext;
                    state <= seqFetch;
                end
                default: state <= seqHalted; // parks here.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == seqExecute) begin
            aluResult <= aluOut;
            if (ctrl.jumpReg) begin
                pcNext <= rsValue;
            end else if (ctrl.jump) begin
                pcNext <= {pc[wordWidth-1:targetWidth], instr[targetWidth-1:0]};
            end else if (takeBranch) begin
                pcNext <= pcPlus1 + immExt;
            end else begin
                pcNext <= pcPlus1;
            end
        end
        if (state == seqMemAccess && readM && inputReady) begin
            memData <= readData;
        end
    end

    strobeExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(readM && writeM));

    // store held until memory accepts it.
    writeHold: assert property (@(posedge clk) disable iff (!rstN)
        writeM && !ackOutput |=> writeM && $stable(address) && $stable(writeData));

endmodule

`default_nettype wire

/* isaPkg.sv */
`default_nettype none

package isaPkg;

    localparam int wordWidth    = 16;
    localparam int regAddrWidth = 2;
    localparam int numRegs      = 2 ** regAddrWidth;
    localparam int opcodeWidth  = 4;
    localparam int funcWidth    = 6;
    localparam int immWidth     = 8;
    localparam int targetWidth  = 12;

    localparam logic [regAddrWidth-1:0] linkReg = 2'd2; // jal and jrl write here.

    typedef enum logic [opcodeWidth-1:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opBgz   = 4'd2,
        opBlz   = 4'd3,
        opAdi   = 4'd4,
        opOri   = 4'd5,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opJal   = 4'd10,
        opRtype = 4'd15
    } opcodeT;

    // function field of the r-type group.
    typedef enum logic [funcWidth-1:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnNot = 6'd4,
        fnTcp = 6'd5,
        fnShl = 6'd6,
        fnShr = 6'd7,
        fnJpr = 6'd25,
        fnJrl = 6'd26,
        fnHlt = 6'd29
    } funcT;

endpackage

`default_nettype wire

/* regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [isaPkg::regAddrWidth-1:0]   readAddr1,
    input  logic [isaPkg::regAddrWidth-1:0]   readAddr2,
    input  logic [isaPkg::regAddrWidth-1:0]   writeAddr,
    input  logic                              writeEnable,
    input  logic [isaPkg::wordWidth-1:0]      writeValue,
    output logic [isaPkg::wordWidth-1:0]      readValue1,
    output logic [isaPkg::wordWidth-1:0]      readValue2
);
    import isaPkg::*;

    logic [wordWidth-1:0] regs [numRegs];

    // one write port, taken on the edge.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeValue;
        end
    end

    assign readValue1 = regs[readAddr1]; // no bypass.
    assign readValue2 = regs[readAddr2];

endmodule

`default_nettype wire

/* src.f */
isaPkg.sv
cpuPkg.sv
regFile.sv
alu.sv
controlUnit.sv
datapath.sv
cpu.sv
tbMemory.sv
tbCpu.sv

/* tbCpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tbCpu;
    import isaPkg::*;

    logic                 clk;
    logic                 rstN;
    logic                 readM;
    logic                 writeM;
    logic                 inputReady;
    logic                 ackOutput;
    logic                 halted;
    logic [wordWidth-1:0] address;
    logic [wordWidth-1:0] writeData;
    logic [wordWidth-1:0] readData;

    int   errors;
    int   checks;
    int   protocolErrors;
    int   resetErrors;
    int   testsPassed;
    int   testsFailed;
    int   cycles;
    int   mark;
    logic timedOut;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    cpu i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .writeData  (writeData),
        .readData   (readData),
        .inputReady (inputReady),
        .ackOutput  (ackOutput),
        .halted     (halted)
    );

    tbMemory i_mem (
        .clk        (clk),
        .rstN       (rstN),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .writeData  (writeData),
        .readData   (readData),
        .inputReady (inputReady),
        .ackOutput  (ackOutput)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus protocol checked every cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    readHeld: assert property (@(posedge clk) disable iff (!rstN)
        readM && !inputReady |=> readM)
        else begin
            protocolErrors++;
            $display("readM dropped before inputReady at %0t", $time);
        end

    writeHeld: assert property (@(posedge clk) disable iff (!rstN)
        writeM && !ackOutput |=> writeM && $stable(address) && $stable(writeData))
        else begin
            protocolErrors++;
            $display("write dropped or address/data changed before ackOutput at %0t", $time);
        end

    oneStrobe: assert property (@(posedge clk) disable iff (!rstN) !(readM && writeM))
        else begin
            protocolErrors++;
            $display("readM and writeM high together at %0t", $time);
        end

    // whole address, upper byte included.
    addrInRange: assert property (@(posedge clk) disable iff (!rstN)
        (readM || writeM) |-> address[wordWidth-1:8] == '0)
        else begin
            protocolErrors++;
            $display("MISMATCH at %0t: address %h lies outside the memory", $time, address);
        end

    task automatic checkWord(input logic [7:0] addr, input logic [15:0] expected,
                             input string what);
        logic [15:0] actual;
        actual = i_mem.mem[addr];
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("MISMATCH at %0t: %s mem[%h] = %h, expected %h",
                     $time, what, addr, actual, expected);
        end
    endtask

    task automatic reportTest(input string name, input int failures);
        if (failures == 0) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: FAILED with %0d errors", name, failures);
        end
    endtask

    initial begin
        errors         = 0;
        checks         = 0;
        protocolErrors = 0;
        resetErrors    = 0;
        testsPassed    = 0;
        testsFailed    = 0;
        rstN           = 1'b0;

        repeat (5) begin
            @(posedge clk);
            #1;
            checks++;
            assert (!readM && !writeM && !halted) else begin
                resetErrors++;
                $display("strobe or halted high during reset at %0t", $time);
            end
        end
        rstN = 1'b1;

        cycles = 0;
        while (!halted && cycles < 5000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        timedOut = !halted;

        mark = errors;
        checkWord(8'h80, 16'h1234, "lhi/ori");
        checkWord(8'h81, 16'h1230, "adi");
        checkWord(8'h82, 16'h2464, "add");
        checkWord(8'h83, 16'h0004, "sub");
        checkWord(8'h84, 16'h1230, "and");
        checkWord(8'h85, 16'h1234, "orr");
        checkWord(8'h86, 16'hEDCB, "not");
        checkWord(8'h87, 16'hEDCC, "tcp");
        checkWord(8'h88, 16'hF6E6, "shr");
        checkWord(8'h89, 16'h2468, "shl");
        reportTest("arithmetic", errors - mark);

        mark = errors;
        checkWord(8'h70, 16'h1112, "lwd+adi");
        checkWord(8'h71, 16'h5F0F, "lwd+not");
        checks++;
        assert (i_mem.writeCount == 23) else begin
            errors++;
            $display("MISMATCH at %0t: %0d writes seen, expected 23", $time, i_mem.writeCount);
        end
        reportTest("loads and stores", errors - mark);

        mark = errors;
        for (int k = 0; k < 8; k++) begin
            checkWord(8'h90 + 8'(k), 16'(k + 1), "branch marker");
        end
        checkWord(8'hA0, 16'hEEA0, "wrong-path store");   // untouched fill.
        reportTest("branches", errors - mark);

        mark = errors;
        checkWord(8'h98, 16'h003D, "jal link");
        checkWord(8'h99, 16'h0009, "jpr target marker");
        checkWord(8'h9A, 16'h0048, "jrl link");
        reportTest("jumps", errors - mark);

        mark = errors;
        if (timedOut) begin
            errors++;
            $display("halted never rose within %0d cycles", cycles);
        end
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            checks++;
            assert (!readM && !writeM) else begin
                errors++;
                $display("memory strobe seen after halt at %0t", $time);
            end
        end
        reportTest("halt", errors - mark);

        reportTest("reset and handshake", resetErrors + protocolErrors);
        errors = errors + resetErrors + protocolErrors;

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 testsPassed, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tbMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module tbMemory (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         readM,
    input  logic                         writeM,
    input  logic [isaPkg::wordWidth-1:0] address,
    input  logic [isaPkg::wordWidth-1:0] writeData,
    output logic [isaPkg::wordWidth-1:0] readData,
    output logic                         inputReady,
    output logic                         ackOutput
);
    import isaPkg::*;

    localparam int memWords = 256;
    localparam int imageLen = 75;

    // test program, hand assembled from address 0.
    localparam logic [wordWidth-1:0] image [imageLen] = '{
        16'h6112, 16'h5534, 16'h5F80, 16'h46FC, 16'h8D00, 16'h8E01,  // lhi, ori, adi.
        16'hF600, 16'h8C02, 16'hF601, 16'h8C03, 16'hF602, 16'h8C04,
        16'hF603, 16'h8C05, 16'hF604, 16'h8C06, 16'hF605, 16'h8C07,
        16'hF007, 16'h8C08, 16'hF606, 16'h8C09,
        16'h7DF0, 16'h7EF1, 16'h4501, 16'hF884, 16'h8DF0, 16'h8EF1,  // load, modify, store.
        16'h6000, 16'hF885,
        16'h0601, 16'h8F20, 16'h4001, 16'h8C10,                      // bne taken.
        16'h0501, 16'h4001, 16'h8C11,
        16'h1501, 16'h8F20, 16'h4001, 16'h8C12,                      // beq taken.
        16'h1601, 16'h4001, 16'h8C13,
        16'h2401, 16'h8F20, 16'h4001, 16'h8C14,                      // bgz taken.
        16'h2801, 16'h4001, 16'h8C15,
        16'h3801, 16'h8F20, 16'h4001, 16'h8C16,                      // blz taken.
        16'h3401, 16'h4001, 16'h8C17,
        16'h903C, 16'h8F20, 16'hA03E, 16'h8F20, 16'h8E18,            // jmp, jal.
        16'h6100, 16'h4543, 16'hF419, 16'h8F20, 16'h4001, 16'h8C19,  // jpr.
        16'h6100, 16'h4549, 16'hF41A, 16'h8F20, 16'h8E1A, 16'hF01D   // jrl, hlt.
    };

    logic [wordWidth-1:0] mem [memWords];
    logic [31:0]          lfsr;
    int                   writeCount;
    int                   delay;

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        lfsr       = 32'h6828_ae47;
        readData   = '0;
        inputReady = 1'b0;
        ackOutput  = 1'b0;
        writeCount = 0;
        for (int i = 0; i < memWords; i++) begin
            mem[i] = {8'hEE, 8'(i)};   // opcode 14 decodes as a no-op.
        end
        for (int i = 0; i < imageLen; i++) begin
            mem[i] = image[i];
        end
        mem[8'h70] = 16'h1111;
        mem[8'h71] = 16'hA0F0;
    end

    // one request at a time, replies 0 to 3 cycles late.
    always begin
        @(posedge clk);
        #1;
        if (rstN && (readM || writeM) && !inputReady && !ackOutput) begin
            lfsr  = stepLfsr(lfsr);
            lfsr  = stepLfsr(lfsr);
            delay = lfsr[1:0];
            for (int i = 0; i < delay; i++) begin
                @(posedge clk);
                #1;
            end
            if (readM) begin
                readData   = mem[address[7:0]];
                inputReady = 1'b1;
            end else begin
                mem[address[7:0]] = writeData;
                writeCount++;
                $display("write mem[%h] <= %h at %0t", address, writeData, $time);
                ackOutput = 1'b1;
            end
            do begin
                @(posedge clk);
                #1;
            end while (readM || writeM);
            inputReady = 1'b0;
            ackOutput  = 1'b0;
        end
    end

endmodule

`default_nettype wire
